// ==== vid_to_stream.f ====
+incdir+common
common/vid_in_pkg.sv
source/video_input_stage.sv
capture/lock_tracker.sv
capture/packet_writer.sv
source/stream_fifo.sv
source/vid_to_stream.sv
verification/vid_to_stream_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vid_to_stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module vid_to_stream_tb -Mdir obj_dir -o vid_to_stream_sim \
        -f vid_to_stream.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vid_to_stream_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in sim.log"
exit 1

// ==== verification/vid_to_stream_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vid_in_macros.svh"

module vid_to_stream_tb
    import vid_in_pkg::*;
();

    localparam int          W            = `VID_DATA_WIDTH;
    localparam logic [31:0] LCG_SEED     = 32'h1c90856e;
    localparam int          READY_LOW    = 0;
    localparam int          READY_HIGH   = 1;
    localparam int          READY_RANDOM = 2;

    logic         rst_vid_clk;
    logic         vid_clk_int;
    logic [W-1:0] vid_data;
    logic         vid_datavalid;
    logic         vid_h_sync;
    logic         vid_v_sync;
    logic         vid_locked;
    logic         enable;
    logic         clear_overflow;
    logic         out_ready = 1'b0;
    logic         out_valid;
    stream_beat_t out_beat;
    logic         out_sop;
    logic         overflow;

    // beats kept as {sop, eop, data}
    logic [W+1:0] exp_q[$];
    logic [W+1:0] rcv_q[$];
    logic [31:0]  pix_seed;
    logic [31:0]  rdy_seed = LCG_SEED;
    int           ready_mode = READY_LOW;

    vid_to_stream uut (
        .rst_vid_clk    (rst_vid_clk),
        .vid_clk_int    (vid_clk_int),
        .vid_data       (vid_data),
        .vid_datavalid  (vid_datavalid),
        .vid_h_sync     (vid_h_sync),
        .vid_v_sync     (vid_v_sync),
        .vid_locked     (vid_locked),
        .enable         (enable),
        .clear_overflow (clear_overflow),
        .out_ready      (out_ready),
        .out_valid      (out_valid),
        .out_beat       (out_beat),
        .out_sop        (out_sop),
        .overflow       (overflow)
    );

    always #4 rst_vid_clk = ~rst_vid_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ready set on the falling edge and the beat moves on the next rising edge
    always @(negedge rst_vid_clk) begin
        logic ready_now;
        ready_now = (ready_mode == READY_HIGH);
        if (ready_mode == READY_RANDOM) begin
            rdy_seed  = lcg_next(rdy_seed);
            ready_now = rdy_seed[20];
        end
        out_ready = ready_now;
        if (!vid_clk_int && out_valid && ready_now) begin
            rcv_q.push_back({out_sop, out_beat.eop, out_beat.data});
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error: %s is 0x%h, expected 0x%h",
                                     name, actual, expected));
        end
    endtask

    task automatic drive_cycle(input logic [W-1:0] data, input logic dv,
                               input logic hs, input logic vs);
        @(negedge rst_vid_clk);
        vid_data      = data;
        vid_datavalid = dv;
        vid_h_sync    = hs;
        vid_v_sync    = vs;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle('0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic apply_reset();
        @(negedge rst_vid_clk);
        vid_clk_int    = 1'b1;
        vid_locked     = 1'b0;
        enable         = 1'b0;
        clear_overflow = 1'b0;
        ready_mode     = READY_LOW;
        idle_cycles(5);
        vid_clk_int = 1'b0;
        exp_q.delete();
        rcv_q.delete();
    endtask

    task automatic send_vsync();
        repeat (6) drive_cycle('0, 1'b0, 1'b0, 1'b1);
        idle_cycles(4);
    endtask

    // hsync pulse, blanking gap, then m pixels from the LCG
    task automatic send_line(input int m, input logic record);
        logic [W-1:0] pix;
        repeat (2) drive_cycle('0, 1'b0, 1'b1, 1'b0);
        idle_cycles(4);
        repeat (m) begin
            pix_seed = lcg_next(pix_seed);
            pix      = pix_seed[31 -: W];
            drive_cycle(pix, 1'b1, 1'b0, 1'b0);
            if (record) begin
                exp_q.push_back({2'b00, pix});
            end
        end
        idle_cycles(3);
    endtask

    task automatic start_packet();
        exp_q.push_back({1'b1, 1'b0, W'(`VID_HEADER_TYPE)});
    endtask

    task automatic end_packet();
        logic [W+1:0] last;
        last    = exp_q.pop_back();
        last[W] = 1'b1;
        exp_q.push_back(last);
    endtask

    task automatic send_field(input int lines, input int m, input logic record);
        send_vsync();
        if (record) begin
            start_packet();
        end
        repeat (lines) send_line(m, record);
    endtask

    task automatic lock_and_enable();
        @(negedge rst_vid_clk);
        vid_locked = 1'b1;
        idle_cycles(4);
        enable = 1'b1;
        idle_cycles(4);
        // ends before the first end of vsync after lock
        send_field(2, 6, 1'b0);
    endtask

    task automatic wait_for_beats(input int count, input int limit);
        int cycles;
        cycles = 0;
        while (rcv_q.size() < count) begin
            if (cycles >= limit) begin
                report_failure("timed out waiting for output beats");
            end
            @(negedge rst_vid_clk);
            cycles++;
        end
    endtask

    task automatic drain_and_compare();
        logic [W+1:0] got;
        logic [W+1:0] want;
        wait_for_beats(exp_q.size(), 3000);
        idle_cycles(30);
        check_value("beat count", 32'(rcv_q.size()), 32'(exp_q.size()));
        foreach (exp_q[i]) begin
            got  = rcv_q[i];
            want = exp_q[i];
            check_value("out_sop", 32'(got[W+1]), 32'(want[W+1]));
            check_value("out_beat.eop", 32'(got[W]), 32'(want[W]));
            check_value("out_beat.data", 32'(got[W-1:0]), 32'(want[W-1:0]));
        end
    endtask

    task automatic test_reset_state();
        apply_reset();
        repeat (50) begin
            @(negedge rst_vid_clk);
            check_value("out_valid", 32'(out_valid), 32'(0));
            check_value("overflow", 32'(overflow), 32'(0));
            check_value("capturing", 32'(uut.capturing), 32'(0));
            check_value("wr_valid", 32'(uut.wr_valid), 32'(0));
        end
    endtask

    task automatic test_fields(input int mode);
        apply_reset();
        ready_mode = mode;
        lock_and_enable();
        send_field(3, 8, 1'b1);
        end_packet();
        send_field(3, 8, 1'b1);
        end_packet();
        send_vsync();
        drain_and_compare();
        check_value("overflow", 32'(overflow), 32'(0));
    endtask

    task automatic test_enable_boundary();
        apply_reset();
        ready_mode = READY_HIGH;
        lock_and_enable();
        send_vsync();
        start_packet();
        send_line(8, 1'b1);
        enable = 1'b0;
        send_line(8, 1'b1);
        send_line(8, 1'b1);
        end_packet();
        send_field(2, 6, 1'b0);
        send_vsync();
        drain_and_compare();
    endtask

    task automatic test_lock_loss();
        apply_reset();
        ready_mode = READY_HIGH;
        lock_and_enable();
        send_vsync();
        start_packet();
        send_line(8, 1'b1);
        send_line(8, 1'b1);
        end_packet();
        // drop lock in the blanking gap
        vid_locked = 1'b0;
        send_line(8, 1'b0);
        send_line(8, 1'b0);
        send_field(2, 6, 1'b0);
        vid_locked = 1'b1;
        send_field(2, 6, 1'b0);
        send_field(2, 8, 1'b1);
        end_packet();
        send_vsync();
        drain_and_compare();
    endtask

    task automatic test_overflow();
        logic [W+1:0] tail;
        apply_reset();
        ready_mode = READY_LOW;
        lock_and_enable();
        send_field(5, 16, 1'b1);
        check_value("overflow", 32'(overflow), 32'(1));
        // buffer keeps the first beats and the latest pixel closes the packet
        tail = exp_q.pop_back();
        while (exp_q.size() > `VID_FIFO_DEPTH) begin
            exp_q.delete(exp_q.size() - 1);
        end
        exp_q.push_back({1'b0, 1'b1, tail[W-1:0]});
        ready_mode = READY_HIGH;
        drain_and_compare();
        check_value("overflow", 32'(overflow), 32'(1));
        @(negedge rst_vid_clk);
        clear_overflow = 1'b1;
        @(negedge rst_vid_clk);
        clear_overflow = 1'b0;
        check_value("overflow", 32'(overflow), 32'(0));
        idle_cycles(5);
        check_value("overflow", 32'(overflow), 32'(0));
    endtask

    initial begin
        rst_vid_clk    = 1'b0;
        vid_clk_int    = 1'b1;
        vid_data       = '0;
        vid_datavalid  = 1'b0;
        vid_h_sync     = 1'b0;
        vid_v_sync     = 1'b0;
        vid_locked     = 1'b0;
        enable         = 1'b0;
        clear_overflow = 1'b0;
        pix_seed       = LCG_SEED;

        test_reset_state();
        test_fields(READY_HIGH);
        test_fields(READY_RANDOM);
        test_enable_boundary();
        test_lock_loss();
        test_overflow();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/vid_to_stream.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vid_in_macros.svh"

module vid_to_stream
    import vid_in_pkg::*;
(
    input  wire                       rst_vid_clk,
    input  wire                       vid_clk_int,
    input  wire [`VID_DATA_WIDTH-1:0] vid_data,
    input  wire                       vid_datavalid,
    input  wire                       vid_h_sync,
    input  wire                       vid_v_sync,
    input  wire                       vid_locked,
    input  wire                       enable,
    input  wire                       clear_overflow,
    input  wire                       out_ready,
    output logic                      out_valid,
    output stream_beat_t              out_beat,
    output logic                      out_sop,
    output logic                      overflow
);

    vid_sample_t  sample;
    sync_events_t events;
    logic         capturing;
    logic         overflow_event;
    logic         wr_valid;
    logic         wr_ready;
    stream_beat_t wr_beat;

    video_input_stage u_input_stage (
        .rst_vid_clk   (rst_vid_clk),
        .vid_clk_int   (vid_clk_int),
        .vid_data      (vid_data),
        .vid_datavalid (vid_datavalid),
        .vid_h_sync    (vid_h_sync),
        .vid_v_sync    (vid_v_sync),
        .sample        (sample),
        .events        (events)
    );

    lock_tracker u_lock_tracker (
        .rst_vid_clk    (rst_vid_clk),
        .vid_clk_int    (vid_clk_int),
        .vid_locked     (vid_locked),
        .enable         (enable),
        .events         (events),
        .overflow_event (overflow_event),
        .capturing      (capturing)
    );

    packet_writer u_packet_writer (
        .rst_vid_clk    (rst_vid_clk),
        .vid_clk_int    (vid_clk_int),
        .sample         (sample),
        .events         (events),
        .capturing      (capturing),
        .vid_locked     (vid_locked),
        .wr_ready       (wr_ready),
        .clear_overflow (clear_overflow),
        .wr_valid       (wr_valid),
        .wr_beat        (wr_beat),
        .overflow_event (overflow_event),
        .overflow       (overflow)
    );

    stream_fifo #(
        .beat_t (stream_beat_t)
    ) u_stream_fifo (
        .rst_vid_clk (rst_vid_clk),
        .vid_clk_int (vid_clk_int),
        .wr_valid    (wr_valid),
        .wr_beat     (wr_beat),
        .out_ready   (out_ready),
        .wr_ready    (wr_ready),
        .out_valid   (out_valid),
        .out_beat    (out_beat),
        .out_sop     (out_sop)
    );

endmodule

`default_nettype wire

// ==== source/stream_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vid_in_macros.svh"

module stream_fifo
    import vid_in_pkg::*;
#(
    parameter type beat_t = stream_beat_t
) (
    input  wire   rst_vid_clk,
    input  wire   vid_clk_int,
    input  wire   wr_valid,
    input  beat_t wr_beat,
    input  wire   out_ready,
    output logic  wr_ready,
    output logic  out_valid,
    output beat_t out_beat,
    output logic  out_sop
);

    localparam int DEPTH = `VID_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    beat_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;
    logic          sop_pending;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + AW'(1);
    endfunction

    assign wr_ready  = (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign do_wr     = wr_valid & wr_ready;
    assign do_rd     = out_valid & out_ready;

    // head of the buffer shows without a read request
    assign out_beat = mem[rd_ptr];
    assign out_sop  = out_valid & sop_pending;

    always_ff @(posedge rst_vid_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge rst_vid_clk or posedge vid_clk_int) begin
        if (vid_clk_int) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            sop_pending <= 1'b1;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr      <= next_ptr(rd_ptr);
                // next beat opens a packet after an eop
                sop_pending <= out_beat.eop;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge rst_vid_clk) disable iff (vid_clk_int)
        count <= CW'(DEPTH));

    // stalled output holds its beat
    assert property (@(posedge rst_vid_clk) disable iff (vid_clk_int)
        out_valid && !out_ready |=> out_valid && $stable(out_beat) && $stable(out_sop));

endmodule

`default_nettype wire

// ==== capture/packet_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vid_in_macros.svh"

module packet_writer
    import vid_in_pkg::*;
(
    input  wire          rst_vid_clk,
    input  wire          vid_clk_int,
    input  vid_sample_t  sample,
    input  sync_events_t events,
    input  wire          capturing,
    input  wire          vid_locked,
    input  wire          wr_ready,
    input  wire          clear_overflow,
    output logic         wr_valid,
    output stream_beat_t wr_beat,
    output logic         overflow_event,
    output logic         overflow
);

    logic                       held_valid;
    logic [`VID_DATA_WIDTH-1:0] held_data;
    logic                       locked_q;
    logic                       lost_lock;
    logic                       overflow_pend;
    logic                       overflow_nxt;
    logic                       pixel_in;
    logic                       header;
    logic                       close;
    logic                       pkt_open;

    assign lost_lock = locked_q & ~vid_locked;

    // space is back after a dropped beat
    assign overflow_event = overflow_pend & wr_ready;

    // a packet may only start at the beginning of a line
    assign pixel_in = capturing & sample.active & (held_valid | events.start_of_active);
    assign header   = pixel_in & ~held_valid;

    // flush the held pixel as the last one of the packet
    assign close = held_valid & (events.start_of_vsync | lost_lock | overflow_event);

    assign wr_valid = pixel_in | close;
    assign wr_beat  = '{
        data: header ? `VID_DATA_WIDTH'(`VID_HEADER_TYPE) : held_data,
        eop:  close
    };

    // beats offered to a full buffer are lost
    assign overflow_nxt = (wr_valid | overflow_pend) & ~wr_ready;

    always_ff @(posedge rst_vid_clk) begin
        if (pixel_in) begin
            held_data <= sample.data;
        end
    end

    always_ff @(posedge rst_vid_clk or posedge vid_clk_int) begin
        if (vid_clk_int) begin
            held_valid    <= 1'b0;
            locked_q      <= 1'b0;
            overflow_pend <= 1'b0;
            overflow      <= 1'b0;
            pkt_open      <= 1'b0;
        end else begin
            locked_q      <= vid_locked;
            overflow_pend <= overflow_nxt;
            overflow      <= (overflow | overflow_nxt) & ~clear_overflow;

            // keep the last pixel until eop can be written
            if (!overflow_nxt) begin
                held_valid <= (pixel_in | held_valid) & ~close;
            end

            if (wr_valid && wr_ready) begin
                pkt_open <= header | (pkt_open & ~wr_beat.eop);
            end
        end
    end

    // a new header only after the previous packet got its eop
    assert property (@(posedge rst_vid_clk) disable iff (vid_clk_int)
        wr_valid && wr_ready && header |-> !pkt_open);

endmodule

`default_nettype wire

// ==== capture/lock_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vid_in_macros.svh"

module lock_tracker
    import vid_in_pkg::*;
(
    input  wire          rst_vid_clk,
    input  wire          vid_clk_int,
    input  wire          vid_locked,
    input  wire          enable,
    input  sync_events_t events,
    input  wire          overflow_event,
    output logic         capturing
);

    localparam int CNT_W = $clog2(`VID_LOCK_LINES + 1);

    logic [CNT_W-1:0] line_count;
    logic [CNT_W-1:0] count_next;
    logic             locked_next;

    // count hsyncs down to zero, then stay locked
    assign count_next = (events.start_of_hsync && line_count != '0) ?
                        line_count - CNT_W'(1) : line_count;
    assign locked_next = (count_next == '0);

    always_ff @(posedge rst_vid_clk or posedge vid_clk_int) begin
        if (vid_clk_int) begin
            line_count <= CNT_W'(`VID_LOCK_LINES);
            capturing  <= 1'b0;
        end else if (!vid_locked || overflow_event) begin
            // lost lock or overflow forces a relock
            line_count <= CNT_W'(`VID_LOCK_LINES);
            capturing  <= 1'b0;
        end else begin
            line_count <= count_next;
            // enable only changes at a field boundary
            if (events.end_of_vsync) begin
                capturing <= enable & locked_next;
            end
        end
    end

    // capture opens only when vsync ends with enable set
    assert property (@(posedge rst_vid_clk) disable iff (vid_clk_int)
        $rose(capturing) |-> $past(events.end_of_vsync && enable && vid_locked));

endmodule

`default_nettype wire

// ==== source/video_input_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vid_in_macros.svh"

module video_input_stage
    import vid_in_pkg::*;
(
    input  wire                       rst_vid_clk,
    input  wire                       vid_clk_int,
    input  wire [`VID_DATA_WIDTH-1:0] vid_data,
    input  wire                       vid_datavalid,
    input  wire                       vid_h_sync,
    input  wire                       vid_v_sync,
    output vid_sample_t               sample,
    output sync_events_t              events
);

    logic [`VID_DATA_WIDTH-1:0] data_q;
    logic                       active_q;
    logic                       h_sync_q;
    logic                       v_sync_q;

    always_ff @(posedge rst_vid_clk) begin
        data_q <= vid_data;
    end

    always_ff @(posedge rst_vid_clk or posedge vid_clk_int) begin
        if (vid_clk_int) begin
            active_q <= 1'b0;
            h_sync_q <= 1'b0;
            v_sync_q <= 1'b0;
            events   <= '0;
        end else begin
            active_q <= vid_datavalid;
            h_sync_q <= vid_h_sync;
            v_sync_q <= vid_v_sync;

            // compare new level with the one already held
            events.start_of_hsync  <= vid_h_sync & ~h_sync_q;
            events.start_of_vsync  <= vid_v_sync & ~v_sync_q;
            events.end_of_vsync    <= ~vid_v_sync & v_sync_q;
            events.start_of_active <= vid_datavalid & ~active_q;
        end
    end

    // events line up with the sample that shows the edge
    assign sample = '{
        data:   data_q,
        active: active_q,
        h_sync: h_sync_q,
        v_sync: v_sync_q
    };

endmodule

`default_nettype wire

// ==== common/vid_in_pkg.sv ====
`default_nettype none

`include "vid_in_macros.svh"

package vid_in_pkg;

    // one registered input sample
    typedef struct packed {
        logic [`VID_DATA_WIDTH-1:0] data;
        logic                       active;
        logic                       h_sync;
        logic                       v_sync;
    } vid_sample_t;

    // single-cycle markers from the input stage
    typedef struct packed {
        logic start_of_hsync;
        logic start_of_vsync;
        logic end_of_vsync;
        logic start_of_active;
    } sync_events_t;

    // one buffered beat
    typedef struct packed {
        logic [`VID_DATA_WIDTH-1:0] data;
        logic                       eop;
    } stream_beat_t;

endpackage

`default_nettype wire

// ==== common/vid_in_macros.svh ====
`ifndef VID_IN_MACROS_SVH
`define VID_IN_MACROS_SVH

// pixel width of two 10-bit planes side by side
`define VID_DATA_WIDTH 20

// buffer depth in beats
`define VID_FIFO_DEPTH 64

// hsync rising edges needed after the source reports lock
`define VID_LOCK_LINES 2

// first beat of every video packet
`define VID_HEADER_TYPE 0

`endif
